// ==== hdl/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Datapath width
`define XLEN            32

////////////////////////////////////////////////////////////////////////////
// Machine CSR numbers
////////////////////////////////////////////////////////////////////////////
`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344

// Timer bus addresses, CLINT style layout
`define MTIME_LO        32'h0200_BFF8
`define MTIME_HI        32'h0200_BFFC
`define MTIMECMP_LO     32'h0200_4000
`define MTIMECMP_HI     32'h0200_4004

// Trap vector, direct mode so two LSBs zero
`define MTVEC_FIXED     32'h0000_0100

// Only MTIE (bit 7) is writable in mie
`define MIE_WRITE_MASK  32'h0000_0080

// Interrupt flag plus machine timer code
`define CAUSE_M_TIMER   32'h8000_0007

`endif

// ==== hdl/csr_pkg.sv ====
`include "csr_consts.svh"

package csr_pkg;

  //////////////////////////////////////////////////////////////////////////
  // CSR instruction types
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_NOP = 2'b00,  // No access side effects
    CSR_RW  = 2'b01,  // Swap
    CSR_RS  = 2'b10,  // Set bits
    CSR_RC  = 2'b11   // Clear bits
  } csr_op_e;

  typedef logic [11:0] csr_num_t;

  // mstatus bit layout, only mie, mpie and mpp are live here
  typedef struct packed {
    logic [18:0] rsv_hi;    // sd, wpri, tsr..fs
    logic [1:0]  mpp;       // Bits 12:11
    logic [2:0]  rsv_mid;   // wpri, spp
    logic        mpie;      // Bit 7
    logic [2:0]  rsv_lo2;   // wpri, spie, upie
    logic        mie;       // Bit 3
    logic [2:0]  rsv_lo;    // wpri, sie, uie
  } mstatus_t;

  // One CSR word, read as plain data or as mstatus fields
  typedef union packed {
    logic [`XLEN-1:0] raw;
    mstatus_t         status;
  } csr_word_u;

  //////////////////////////////////////////////////////////////////////////
  // Inter-block records
  //////////////////////////////////////////////////////////////////////////

  // Interrupt enables and pending flag for the trap decision
  typedef struct packed {
    logic mstatus_mie;
    logic mie_mtie;
    logic mtip;
  } csr_status_t;

  // Trap commit, applied by the register file on the next edge
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] epc;
    logic [`XLEN-1:0] cause;
    logic [`XLEN-1:0] tval;
  } trap_commit_t;

  // Memory-mapped timer request, single cycle
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } timer_bus_t;

endpackage

// ==== hdl/csr_regfile.sv ====
`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_regfile (
  input  logic                  clk,
  input  logic                  rst,
  // CSR instruction port
  input  csr_pkg::csr_op_e      op_i,
  input  csr_pkg::csr_num_t     addr_i,
  input  logic [`XLEN-1:0]      wdata_i,
  output logic [`XLEN-1:0]      rdata_o,    // Old value, same cycle
  // Timer pending flag from the timer block
  input  logic                  mtip_i,
  // Trap side
  input  csr_pkg::trap_commit_t trap_i,
  output csr_pkg::csr_status_t  status_o,
  output logic [`XLEN-1:0]      mtvec_o,
  output logic [`XLEN-1:0]      mepc_o
);

  import csr_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  csr_word_u        mstatus_q, mstatus_d;
  csr_word_u        mstatus_rd;               // Read view with MPP forced
  logic [`XLEN-1:0] mie_q, mie_d;
  logic [`XLEN-1:0] mscratch_q, mscratch_d;
  logic [`XLEN-1:0] mepc_q, mepc_d;
  logic [`XLEN-1:0] mcause_q, mcause_d;
  logic [`XLEN-1:0] mtval_q, mtval_d;
  logic [`XLEN-1:0] mip_rd;                   // Read-only, pending bits only

  logic             wr_en;
  csr_word_u        wr_word;                  // New value after RW/RS/RC

  // Machine mode only, so MPP always reads 3
  always_comb begin
    mstatus_rd            = mstatus_q;
    mstatus_rd.status.mpp = 2'b11;
  end

  assign mip_rd = {{(`XLEN-8){1'b0}}, mtip_i, 7'b000_0000};

  ////////////////////////////////////////////////////////////////////////////
  // Read mux, combinational on addr_i
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (addr_i)
      `CSR_MSTATUS:  rdata_o = mstatus_rd.raw;
      `CSR_MIE:      rdata_o = mie_q;
      `CSR_MTVEC:    rdata_o = `MTVEC_FIXED;
      `CSR_MIP:      rdata_o = mip_rd;
      `CSR_MSCRATCH: rdata_o = mscratch_q;
      `CSR_MEPC:     rdata_o = mepc_q;
      `CSR_MCAUSE:   rdata_o = mcause_q;
      `CSR_MTVAL:    rdata_o = mtval_q;
      default:       rdata_o = '0;            // Unknown CSRs read zero
    endcase
  end

  // Op decode, RS/RC work on the old value
  always_comb begin
    wr_en       = 1'b1;
    wr_word.raw = wdata_i;
    case (op_i)
      CSR_NOP: wr_en = 1'b0;
      CSR_RW:  wr_word.raw = wdata_i;
      CSR_RS:  wr_word.raw = rdata_o | wdata_i;
      CSR_RC:  wr_word.raw = rdata_o & ~wdata_i;
      default: wr_en = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state, instruction write then trap commit on top
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;

    if (wr_en) begin
      case (addr_i)
        `CSR_MSTATUS: begin
          mstatus_d.raw         = '0;           // Drop all other fields
          mstatus_d.status.mie  = wr_word.status.mie;
          mstatus_d.status.mpie = wr_word.status.mpie;
          mstatus_d.status.mpp  = 2'b11;
        end
        `CSR_MIE:      mie_d      = wr_word.raw & `MIE_WRITE_MASK;
        `CSR_MSCRATCH: mscratch_d = wr_word.raw;
        `CSR_MEPC:     mepc_d     = {wr_word.raw[`XLEN-1:2], 2'b00};
        `CSR_MCAUSE:   mcause_d   = wr_word.raw;
        `CSR_MTVAL:    mtval_d    = wr_word.raw;
        default: ;                              // mtvec, mip, unknown
      endcase
    end

    // Trap wins over any instruction write
    if (trap_i.valid) begin
      mepc_d                = {trap_i.epc[`XLEN-1:2], 2'b00};
      mcause_d              = trap_i.cause;
      mtval_d               = trap_i.tval;
      mstatus_d.status.mpie = mstatus_q.status.mie;  // Stack MIE
      mstatus_d.status.mie  = 1'b0;                  // Mask further irqs
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q.raw <= '0;
      mie_q         <= '0;
      mscratch_q    <= '0;
      mepc_q        <= '0;
      mcause_q      <= '0;
      mtval_q       <= '0;
    end else begin
      mstatus_q     <= mstatus_d;
      mie_q         <= mie_d;
      mscratch_q    <= mscratch_d;
      mepc_q        <= mepc_d;
      mcause_q      <= mcause_d;
      mtval_q       <= mtval_d;
    end
  end

  // Outputs to trap logic and fetch
  assign status_o.mstatus_mie = mstatus_q.status.mie;
  assign status_o.mie_mtie    = mie_q[7];
  assign status_o.mtip        = mtip_i;      // Passed on from timer
  assign mtvec_o              = `MTVEC_FIXED;
  assign mepc_o               = mepc_q;

endmodule

// ==== hdl/csr_subsystem.sv ====
`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_subsystem (
  input  logic                clk,
  input  logic                rst,
  // CSR instruction port
  input  csr_pkg::csr_op_e    op_i,
  input  csr_pkg::csr_num_t   addr_i,
  input  logic [`XLEN-1:0]    wdata_i,
  output logic [`XLEN-1:0]    rdata_o,
  // Memory-mapped timer
  input  csr_pkg::timer_bus_t timer_bus_i,
  output logic [31:0]         timer_rdata_o,
  // Exceptions and trap outputs
  input  logic                exc_req_i,
  input  logic [`XLEN-1:0]    exc_cause_i,
  input  logic [`XLEN-1:0]    exc_tval_i,
  input  logic [`XLEN-1:0]    pc_i,
  output logic                trap_o,
  output logic [`XLEN-1:0]    mtvec_o,
  output logic [`XLEN-1:0]    mepc_o
);

  import csr_pkg::*;

  csr_status_t  status;     // Regfile to trap decision
  trap_commit_t commit;     // Trap decision back to regfile
  logic         mtip;       // Timer pending, routed through regfile

  csr_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .op_i     (op_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .rdata_o  (rdata_o),
    .mtip_i   (mtip),
    .trap_i   (commit),
    .status_o (status),
    .mtvec_o  (mtvec_o),
    .mepc_o   (mepc_o)
  );

  machine_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .bus_i   (timer_bus_i),
    .rdata_o (timer_rdata_o),
    .mtip_o  (mtip)
  );

  trap_ctrl u_trap (
    .status_i    (status),
    .exc_req_i   (exc_req_i),
    .exc_cause_i (exc_cause_i),
    .exc_tval_i  (exc_tval_i),
    .pc_i        (pc_i),
    .commit_o    (commit)
  );

  assign trap_o = commit.valid;   // Same cycle as the decision

endmodule

// ==== hdl/machine_timer.sv ====
`timescale 1ns/1ps

`include "csr_consts.svh"

module machine_timer (
  input  logic                clk,
  input  logic                rst,
  input  csr_pkg::timer_bus_t bus_i,
  output logic [31:0]         rdata_o,     // Same cycle as addr
  output logic                mtip_o       // Sticky pending flag
);

  logic [63:0] mtime_q, mtime_d;
  logic [63:0] mtimecmp_q, mtimecmp_d;
  logic        mtip_q, mtip_d;
  logic        cmp_wr;                     // Either mtimecmp half written

  // Half-word read decode
  always_comb begin
    case (bus_i.addr)
      `MTIME_LO:    rdata_o = mtime_q[31:0];
      `MTIME_HI:    rdata_o = mtime_q[63:32];
      `MTIMECMP_LO: rdata_o = mtimecmp_q[31:0];
      `MTIMECMP_HI: rdata_o = mtimecmp_q[63:32];
      default:      rdata_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Counter, compare register and pending flag
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mtime_d    = mtime_q + 64'd1;          // Free running
    mtimecmp_d = mtimecmp_q;
    cmp_wr     = 1'b0;
    if (bus_i.we) begin
      case (bus_i.addr)
        `MTIME_LO:    mtime_d = {mtime_q[63:32], bus_i.wdata};  // No increment
        `MTIME_HI:    mtime_d = {bus_i.wdata, mtime_q[31:0]};
        `MTIMECMP_LO: begin
          mtimecmp_d = {mtimecmp_q[63:32], bus_i.wdata};
          cmp_wr     = 1'b1;
        end
        `MTIMECMP_HI: begin
          mtimecmp_d = {bus_i.wdata, mtimecmp_q[31:0]};
          cmp_wr     = 1'b1;
        end
        default: ;
      endcase
    end

    // Compare write acknowledges, else set and hold
    if (cmp_wr)
      mtip_d = 1'b0;
    else if (mtime_q >= mtimecmp_q)
      mtip_d = 1'b1;
    else
      mtip_d = mtip_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;                    // Far future, nothing pending
      mtip_q     <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      mtip_q     <= mtip_d;
    end
  end

  assign mtip_o = mtip_q;

endmodule

// ==== hdl/trap_ctrl.sv ====
`timescale 1ns/1ps

`include "csr_consts.svh"

module trap_ctrl (
  input  csr_pkg::csr_status_t  status_i,
  // Exception request from the core
  input  logic                  exc_req_i,
  input  logic [`XLEN-1:0]      exc_cause_i,
  input  logic [`XLEN-1:0]      exc_tval_i,
  input  logic [`XLEN-1:0]      pc_i,
  output csr_pkg::trap_commit_t commit_o
);

  logic timer_irq;

  // Global enable, local enable and pending all needed
  assign timer_irq = status_i.mstatus_mie & status_i.mie_mtie & status_i.mtip;

  ////////////////////////////////////////////////////////////////////////////
  // Commit record
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Exceptions ignore MIE
    commit_o.valid = timer_irq | exc_req_i;
    commit_o.epc   = pc_i;
    if (timer_irq) begin
      commit_o.cause = `CAUSE_M_TIMER;     // Interrupt wins the cause
      commit_o.tval  = '0;
    end else begin
      commit_o.cause = exc_cause_i;
      commit_o.tval  = exc_tval_i;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CSR subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module csr_tb -o csr_sim \
  && ./obj_dir/csr_sim | tee sim.log \
  || echo "Build or simulation stopped with an error"

# Pass only when the log holds the pass line
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }

// ==== tb.f ====
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_regfile.sv
hdl/machine_timer.sv
hdl/trap_ctrl.sv
hdl/csr_subsystem.sv
test/csr_tb.sv

// ==== test/csr_tb.sv ====
`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_tb;

  import csr_pkg::*;

  localparam int N_RESET = 8;
  localparam int N_IDLE  = 16;
  localparam int N_CSR   = 400;
  localparam int N_TIMER = 400;
  localparam int N_IRQ   = 120;             // Setup, wait limit and readback
  localparam int N_EXC   = 400;
  localparam int N_TOTAL = N_RESET + N_IDLE + N_CSR + N_TIMER + N_IRQ + N_EXC;
  localparam logic [31:0] IRQ_PC = 32'h0000_2467;  // Low bits set, mepc drops them

  logic        clk, rst;
  csr_op_e     op_i;
  csr_num_t    addr_i;
  logic [31:0] wdata_i, rdata_o, timer_rdata_o;
  timer_bus_t  bus;
  logic        exc_req_i, trap_o;
  logic [31:0] exc_cause_i, exc_tval_i, pc_i, mtvec_o, mepc_o;
  integer      seed;

  // Reference model state
  logic        m_mstat_mie, m_mstat_mpie;
  logic [31:0] m_mie, m_mscratch, m_mepc, m_mcause, m_mtval;
  logic [63:0] m_mtime, m_mtimecmp;
  logic        m_mtip;

  csr_subsystem u_dut (
    .clk (clk), .rst (rst),
    .op_i (op_i), .addr_i (addr_i), .wdata_i (wdata_i), .rdata_o (rdata_o),
    .timer_bus_i (bus), .timer_rdata_o (timer_rdata_o),
    .exc_req_i (exc_req_i), .exc_cause_i (exc_cause_i),
    .exc_tval_i (exc_tval_i), .pc_i (pc_i),
    .trap_o (trap_o), .mtvec_o (mtvec_o), .mepc_o (mepc_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                 // 20 ns period
  end

  // Watchdog sized from the phase lengths
  initial begin
    #((N_TOTAL + 64) * 20);
    $display("Watchdog: the run went past its cycle budget and was stopped");
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model read views
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] exp_csr(input logic [11:0] a);
    case (a)
      `CSR_MSTATUS:  return {19'd0, 2'b11, 3'd0, m_mstat_mpie, 3'd0, m_mstat_mie, 3'd0};
      `CSR_MIE:      return m_mie;
      `CSR_MTVEC:    return `MTVEC_FIXED;
      `CSR_MIP:      return {24'd0, m_mtip, 7'd0};  // MTIP at bit 7
      `CSR_MSCRATCH: return m_mscratch;
      `CSR_MEPC:     return m_mepc;
      `CSR_MCAUSE:   return m_mcause;
      `CSR_MTVAL:    return m_mtval;
      default:       return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] exp_timer(input logic [31:0] a);
    case (a)
      `MTIME_LO:    return m_mtime[31:0];
      `MTIME_HI:    return m_mtime[63:32];
      `MTIMECMP_LO: return m_mtimecmp[31:0];
      `MTIMECMP_HI: return m_mtimecmp[63:32];
      default:      return 32'd0;
    endcase
  endfunction

  function automatic logic exp_irq();
    return m_mstat_mie & m_mie[7] & m_mtip;
  endfunction

  function automatic csr_num_t known_csr(input logic [2:0] k);
    case (k)
      3'd0:    return `CSR_MSTATUS;
      3'd1:    return `CSR_MIE;
      3'd2:    return `CSR_MTVEC;
      3'd3:    return `CSR_MSCRATCH;
      3'd4:    return `CSR_MEPC;
      3'd5:    return `CSR_MCAUSE;
      3'd6:    return `CSR_MTVAL;
      default: return `CSR_MIP;
    endcase
  endfunction

  function automatic logic [31:0] timer_addr(input logic [1:0] k);
    case (k)
      2'd0:    return `MTIME_LO;
      2'd1:    return `MTIME_HI;
      2'd2:    return `MTIMECMP_LO;
      default: return `MTIMECMP_HI;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking and driving
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp_v, act_v);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run aborted");
  endtask

  task automatic drive_idle();
    op_i        = CSR_NOP;
    addr_i      = 12'd0;
    wdata_i     = 32'd0;
    bus.we      = 1'b0;
    bus.addr    = `MTIME_LO;
    bus.wdata   = 32'd0;
    exc_req_i   = 1'b0;
    exc_cause_i = 32'd0;
    exc_tval_i  = 32'd0;
    pc_i        = 32'd0;
  endtask

  task automatic put_csr(input csr_op_e op, input csr_num_t a, input logic [31:0] wd);
    op_i    = op;
    addr_i  = a;
    wdata_i = wd;
  endtask

  task automatic put_bus(input logic we, input logic [31:0] a, input logic [31:0] wd);
    bus.we    = we;
    bus.addr  = a;
    bus.wdata = wd;
  endtask

  // Sample just ahead of the rising edge, all outputs settled
  task automatic settle_and_check(input string name);
    #8;
    check_val({name, " rdata"}, exp_csr(addr_i), rdata_o);
    check_val({name, " timer_rdata"}, exp_timer(bus.addr), timer_rdata_o);
    check_val({name, " trap"}, {31'd0, exp_irq() | exc_req_i}, {31'd0, trap_o});
    check_val({name, " mepc"}, m_mepc, mepc_o);
    check_val({name, " mtvec"}, `MTVEC_FIXED, mtvec_o);
  endtask

  // Model edge: instruction write, trap on top, then timer
  task automatic model_update();
    logic [31:0] old_v, new_v;
    logic        irq, mie_old, cmp_wr;
    logic [63:0] t_nxt, c_nxt;
    irq     = exp_irq();
    mie_old = m_mstat_mie;
    old_v   = exp_csr(addr_i);              // RS and RC build on the old value
    case (op_i)
      CSR_RW:  new_v = wdata_i;
      CSR_RS:  new_v = old_v | wdata_i;
      CSR_RC:  new_v = old_v & ~wdata_i;
      default: new_v = old_v;
    endcase
    if (op_i != CSR_NOP) begin
      case (addr_i)
        `CSR_MSTATUS: begin
          m_mstat_mie  = new_v[3];
          m_mstat_mpie = new_v[7];
        end
        `CSR_MIE:      m_mie      = new_v & `MIE_WRITE_MASK;
        `CSR_MSCRATCH: m_mscratch = new_v;
        `CSR_MEPC:     m_mepc     = new_v & 32'hFFFF_FFFC;
        `CSR_MCAUSE:   m_mcause   = new_v;
        `CSR_MTVAL:    m_mtval    = new_v;
        default: ;                          // mtvec, mip and unknown numbers
      endcase
    end
    if (irq || exc_req_i) begin
      m_mepc       = pc_i & 32'hFFFF_FFFC;
      m_mcause     = irq ? `CAUSE_M_TIMER : exc_cause_i;
      m_mtval      = irq ? 32'd0 : exc_tval_i;
      m_mstat_mpie = mie_old;
      m_mstat_mie  = 1'b0;
    end
    t_nxt  = m_mtime + 64'd1;
    c_nxt  = m_mtimecmp;
    cmp_wr = 1'b0;
    if (bus.we) begin
      case (bus.addr)
        `MTIME_LO:    t_nxt = {m_mtime[63:32], bus.wdata};
        `MTIME_HI:    t_nxt = {bus.wdata, m_mtime[31:0]};
        `MTIMECMP_LO: begin
          c_nxt  = {m_mtimecmp[63:32], bus.wdata};
          cmp_wr = 1'b1;
        end
        `MTIMECMP_HI: begin
          c_nxt  = {bus.wdata, m_mtimecmp[31:0]};
          cmp_wr = 1'b1;
        end
        default: ;
      endcase
    end
    if (cmp_wr)
      m_mtip = 1'b0;
    else if (m_mtime >= m_mtimecmp)         // Pre-edge compare, sticky
      m_mtip = 1'b1;
    m_mtime    = t_nxt;
    m_mtimecmp = c_nxt;
  endtask

  task automatic tick(input string name);
    settle_and_check(name);
    model_update();
    @(negedge clk);
  endtask

  task automatic readback(input csr_num_t a, input logic [31:0] exp_v, input string name);
    put_csr(CSR_NOP, a, 32'd0);
    settle_and_check(name);
    check_val(name, exp_v, rdata_o);
    model_update();
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] exp_v;
    logic        hit;
    int          i;
    int          waited;
    seed = 32'ha1b4;
    rst  = 1'b1;
    drive_idle();
    m_mstat_mie  = 1'b0;
    m_mstat_mpie = 1'b0;
    m_mie        = 32'd0;
    m_mscratch   = 32'd0;
    m_mepc       = 32'd0;
    m_mcause     = 32'd0;
    m_mtval      = 32'd0;
    m_mtime      = 64'd0;
    m_mtimecmp   = '1;                      // Far future after reset
    m_mtip       = 1'b0;
    repeat (N_RESET) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Reset values and a free running mtime
    for (i = 0; i < N_IDLE; i++) begin
      drive_idle();
      addr_i = known_csr(i[2:0]);
      settle_and_check("reset");
      exp_v = 32'd0;
      if (addr_i == `CSR_MSTATUS)
        exp_v = 32'h0000_1800;              // MPP reads 3
      if (addr_i == `CSR_MTVEC)
        exp_v = `MTVEC_FIXED;
      check_val("reset csr value", exp_v, rdata_o);
      check_val("reset mtime_lo", i, timer_rdata_o);
      model_update();
      @(negedge clk);
    end

    // Random CSR instructions, unknown numbers mixed in
    for (i = 0; i < N_CSR; i++) begin
      r        = $random(seed);
      op_i     = csr_op_e'(r[1:0]);
      addr_i   = r[2] ? known_csr(r[5:3]) : r[17:6];
      wdata_i  = $random(seed);
      bus.addr = timer_addr(r[19:18]);
      tick("csr random");
    end

    // Random timer bus traffic
    drive_idle();
    for (i = 0; i < N_TIMER; i++) begin
      r = $random(seed);
      addr_i = known_csr(r[2:0]);
      put_bus(r[3], timer_addr(r[5:4]), $random(seed));
      if (r[6] && bus.addr == `MTIME_LO)
        bus.wdata = {29'h1FFF_FFFF, r[9:7]};  // Near wrap, carry into high half
      pc_i = $random(seed);
      tick("timer random");
    end

    // Timer interrupt program
    drive_idle();
    pc_i = IRQ_PC;
    put_csr(CSR_RW, `CSR_MSTATUS, 32'd0);
    put_bus(1'b1, `MTIMECMP_HI, 32'hFFFF_FFFF);
    tick("irq setup");
    put_csr(CSR_NOP, `CSR_MIP, 32'd0);
    put_bus(1'b1, `MTIME_HI, 32'd0);
    tick("irq setup");
    put_bus(1'b1, `MTIME_LO, 32'd0);
    tick("irq setup");
    put_bus(1'b1, `MTIMECMP_LO, 32'd40);
    tick("irq setup");
    put_bus(1'b1, `MTIMECMP_HI, 32'd0);     // Compare now 40 cycles out
    tick("irq setup");
    put_bus(1'b0, `MTIME_LO, 32'd0);
    put_csr(CSR_RS, `CSR_MIE, 32'h0000_0080);
    tick("irq enable");
    put_csr(CSR_RS, `CSR_MSTATUS, 32'h0000_0008);
    tick("irq enable");
    put_csr(CSR_NOP, `CSR_MIP, 32'd0);
    waited = 0;
    do begin
      settle_and_check("irq wait");         // Exact cycle against the model
      hit = trap_o;
      model_update();
      @(negedge clk);
      waited++;
    end while (!hit && waited < 100);
    if (!hit)
      abort_run("Timer interrupt was never taken after enabling MIE and MTIE");
    check_val("irq mepc", IRQ_PC & 32'hFFFF_FFFC, mepc_o);
    readback(`CSR_MCAUSE, `CAUSE_M_TIMER, "irq mcause");
    readback(`CSR_MSTATUS, 32'h0000_1880, "irq mstatus");  // MPIE set, MIE clear
    readback(`CSR_MTVAL, 32'd0, "irq mtval");
    put_bus(1'b1, `MTIMECMP_HI, 32'hFFFF_FFFF);
    readback(`CSR_MIP, 32'h0000_0080, "irq still pending");
    put_bus(1'b0, `MTIME_LO, 32'd0);
    readback(`CSR_MIP, 32'd0, "irq pending cleared");

    // Random exceptions, MIE toggling, timer armed now and then
    drive_idle();
    put_csr(CSR_RS, `CSR_MIE, 32'h0000_0080);
    tick("exc setup");
    for (i = 0; i < N_EXC; i++) begin
      r           = $random(seed);
      exc_req_i   = r[0];
      exc_cause_i = {28'd0, r[4:1]};
      exc_tval_i  = $random(seed);
      pc_i        = $random(seed);
      case (r[6:5])
        2'd0:    put_csr(CSR_RS, `CSR_MSTATUS, 32'h0000_0008);
        2'd1:    put_csr(CSR_RC, `CSR_MSTATUS, 32'h0000_0008);
        default: put_csr(CSR_NOP, known_csr(r[9:7]), 32'd0);
      endcase
      if (r[12:10] == 3'd0)
        put_bus(1'b1, `MTIMECMP_HI, r[13] ? 32'd0 : 32'hFFFF_FFFF);  // Arm or disarm
      else
        put_bus(1'b0, timer_addr(r[15:14]), 32'd0);
      tick("exception random");
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
